// ==== include/bus_cfg.svh ====
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// command entries held by the queue between host port and bus master
`define BUS_QUEUE_DEPTH 4

// address bits decoded by the on-chip RAM, 256 bytes
`define RAM_ADDR_W 8

// cycles from an accepted strobe to its ack
`define RAM_ACK_LAT 2

// one stall cycle is inserted after this many accepted strobes
`define RAM_STALL_EVERY 3

`endif

// ==== src/bus_pkg.sv ====
package bus_pkg;

	// host side operation codes
	// reads come first so that bit 2 alone does not mark a write
	typedef enum logic [2:0] {
		OP_READB  = 3'd0,
		OP_READBU = 3'd1,
		OP_READH  = 3'd2,
		OP_READHU = 3'd3,
		OP_READW  = 3'd4,
		OP_WRITEB = 3'd5,
		OP_WRITEH = 3'd6,
		OP_WRITEW = 3'd7
	} bus_op_e;

	// wishbone master sequencing
	typedef enum logic [1:0] {
		// waiting for a queued command
		ST_IDLE = 2'd0,
		// strobes and acks in progress
		ST_XFER = 2'd1,
		// one cycle after the last ack
		ST_DONE = 2'd2
	} master_state_e;

endpackage

// ==== src/bus_cmd_if.sv ====
`timescale 1ns/1ps

interface bus_cmd_if;
	import bus_pkg::*;

	logic        valid;
	logic        ready;
	bus_op_e     op;
	logic [31:0] addr;
	logic [31:0] wdata;

	// producer side, fields held while valid is high and ready is low
	modport source (
		output valid, op, addr, wdata,
		input  ready
	);

	modport sink (
		input  valid, op, addr, wdata,
		output ready
	);

endinterface

// ==== src/wb8_if.sv ====
`timescale 1ns/1ps

interface wb8_if;

	logic        cyc;
	logic        stb;
	logic        we;
	logic [31:0] adr;
	logic [7:0]  dat_w;
	logic [7:0]  dat_r;
	logic        ack;
	logic        stall;

	// pipelined mode, a strobe is taken when stb is high and stall is low
	modport master (
		output cyc, stb, we, adr, dat_w,
		input  dat_r, ack, stall
	);

	// one ack per accepted strobe, returned in order
	modport slave (
		input  cyc, stb, we, adr, dat_w,
		output dat_r, ack, stall
	);

endinterface

// ==== src/host_port.sv ====
`timescale 1ns/1ps

module host_port (
	input  logic              CLK_I,
	input  logic              RST_I,
	input  logic              req,
	input  bus_pkg::bus_op_e  op,
	input  logic [31:0]       addr,
	input  logic [31:0]       wdata,
	output logic              ack,
	output logic [31:0]       rdata,
	input  logic              rsp_valid,
	input  logic [31:0]       rsp_data,
	bus_cmd_if.source         cmd
);
	import bus_pkg::*;

	typedef enum logic [1:0] {
		HP_IDLE,
		HP_PUSH,
		HP_WAIT,
		HP_ACK
	} hp_state_e;

	hp_state_e state;
	logic      is_write;

	assign is_write = op inside {OP_WRITEB, OP_WRITEH, OP_WRITEW};

	// host holds its fields stable for the whole request
	assign cmd.valid = (state == HP_PUSH);
	assign cmd.op    = op;
	assign cmd.addr  = addr;
	assign cmd.wdata = wdata;

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			state <= HP_IDLE;
			ack   <= 1'b0;
		end else begin
			case (state)
				HP_IDLE: begin
					if (req)
						state <= HP_PUSH;
				end
				HP_PUSH: begin
					// stays here while the queue is full
					if (cmd.ready) begin
						if (is_write) begin
							// posted write, acknowledged on entry
							ack   <= 1'b1;
							state <= HP_ACK;
						end else begin
							state <= HP_WAIT;
						end
					end
				end
				HP_WAIT: begin
					if (rsp_valid) begin
						ack   <= 1'b1;
						state <= HP_ACK;
					end
				end
				HP_ACK: begin
					// return to zero once the host lets go of req
					if (!req) begin
						ack   <= 1'b0;
						state <= HP_IDLE;
					end
				end
				default: state <= HP_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK_I) begin
		if (state == HP_WAIT && rsp_valid)
			rdata <= rsp_data;
	end

endmodule

// ==== src/cmd_queue.sv ====
`timescale 1ns/1ps
`include "bus_cfg.svh"

module cmd_queue (
	input  logic      CLK_I,
	input  logic      RST_I,
	bus_cmd_if.sink   in,
	bus_cmd_if.source out
);
	import bus_pkg::*;

	localparam int DEPTH = `BUS_QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	bus_op_e     mem_op    [DEPTH];
	logic [31:0] mem_addr  [DEPTH];
	logic [31:0] mem_wdata [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	assign in.ready  = (count != CNT_W'(DEPTH));
	assign out.valid = (count != '0);
	assign push      = in.valid && in.ready;
	assign pop       = out.valid && out.ready;

	// head entry is presented as soon as the queue holds anything
	assign out.op    = mem_op[rd_ptr];
	assign out.addr  = mem_addr[rd_ptr];
	assign out.wdata = mem_wdata[rd_ptr];

	always_ff @(posedge CLK_I) begin
		if (push) begin
			mem_op[wr_ptr]    <= in.op;
			mem_addr[wr_ptr]  <= in.addr;
			mem_wdata[wr_ptr] <= in.wdata;
		end
	end

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// simultaneous push and pop leaves the count unchanged
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== src/wb8_master.sv ====
`timescale 1ns/1ps

module wb8_master (
	input  logic        CLK_I,
	input  logic        RST_I,
	bus_cmd_if.sink     cmd,
	wb8_if.master       wb,
	output logic        rsp_valid,
	output logic [31:0] rsp_data
);
	import bus_pkg::*;

	master_state_e state;

	// decoded from the queue head
	logic [2:0]  dec_bytes;
	logic        dec_write;
	logic        dec_sign;

	// latched command
	logic [31:0] base_addr;
	logic [31:0] wdata_q;
	logic [2:0]  byte_cnt;
	logic        write_q;
	logic        sign_q;

	// strobes issued and acks received, counted apart
	logic [2:0]  stb_cnt;
	logic [2:0]  ack_cnt;
	logic [31:0] rd_buf;
	logic        ext_bit;

	function automatic logic [7:0] lane_byte(input logic [31:0] w, input logic [2:0] idx);
		logic [7:0] b;
		case (idx)
			3'd0:    b = w[7:0];
			3'd1:    b = w[15:8];
			3'd2:    b = w[23:16];
			default: b = w[31:24];
		endcase
		return b;
	endfunction

	always_comb begin
		case (cmd.op)
			OP_READW, OP_WRITEW:            dec_bytes = 3'd4;
			OP_READH, OP_READHU, OP_WRITEH: dec_bytes = 3'd2;
			default:                        dec_bytes = 3'd1;
		endcase
		dec_write = cmd.op inside {OP_WRITEB, OP_WRITEH, OP_WRITEW};
		dec_sign  = cmd.op inside {OP_READB, OP_READH};
	end

	assign cmd.ready = (state == ST_IDLE);
	assign ext_bit   = sign_q & wb.dat_r[7];
	assign rsp_data  = rd_buf;

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			state     <= ST_IDLE;
			wb.cyc    <= 1'b0;
			wb.stb    <= 1'b0;
			wb.we     <= 1'b0;
			rsp_valid <= 1'b0;
			stb_cnt   <= '0;
			ack_cnt   <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (cmd.valid) begin
						// first strobe goes out on the accepting edge
						wb.cyc  <= 1'b1;
						wb.stb  <= 1'b1;
						wb.we   <= dec_write;
						stb_cnt <= 3'd1;
						ack_cnt <= '0;
						state   <= ST_XFER;
					end
				end
				ST_XFER: begin
					// a stalled strobe keeps its address and data
					if (!wb.stb || !wb.stall) begin
						if (stb_cnt != byte_cnt) begin
							wb.stb  <= 1'b1;
							stb_cnt <= stb_cnt + 3'd1;
						end else begin
							wb.stb <= 1'b0;
						end
					end
					if (wb.ack) begin
						ack_cnt <= ack_cnt + 3'd1;
						if (ack_cnt + 3'd1 == byte_cnt) begin
							wb.cyc    <= 1'b0;
							wb.we     <= 1'b0;
							rsp_valid <= !write_q;
							state     <= ST_DONE;
						end
					end
				end
				ST_DONE: begin
					rsp_valid <= 1'b0;
					state     <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// payload side, address, write byte and read assembly
	always_ff @(posedge CLK_I) begin
		if (state == ST_IDLE && cmd.valid) begin
			base_addr <= cmd.addr;
			wdata_q   <= cmd.wdata;
			byte_cnt  <= dec_bytes;
			write_q   <= dec_write;
			sign_q    <= dec_sign;
			wb.adr    <= cmd.addr;
			wb.dat_w  <= cmd.wdata[7:0];
		end else if (state == ST_XFER && (!wb.stb || !wb.stall) && stb_cnt != byte_cnt) begin
			wb.adr   <= base_addr + {29'd0, stb_cnt};
			wb.dat_w <= lane_byte(wdata_q, stb_cnt);
		end

		// lanes 0 and 1 extend upward, later lanes overwrite the extension
		if (state == ST_XFER && wb.ack) begin
			case (ack_cnt)
				3'd0:    rd_buf         <= {{24{ext_bit}}, wb.dat_r};
				3'd1:    rd_buf[31:8]   <= {{16{ext_bit}}, wb.dat_r};
				3'd2:    rd_buf[23:16]  <= wb.dat_r;
				default: rd_buf[31:24]  <= wb.dat_r;
			endcase
		end
	end

endmodule

// ==== src/wb_ram8.sv ====
`timescale 1ns/1ps
`include "bus_cfg.svh"

module wb_ram8 (
	input  logic  CLK_I,
	input  logic  RST_I,
	wb8_if.slave  wb
);

	localparam int ADDR_W = `RAM_ADDR_W;
	localparam int LAT    = `RAM_ACK_LAT;
	localparam int EVERY  = `RAM_STALL_EVERY;
	localparam int SCNT_W = $clog2(EVERY + 1);

	logic [7:0] mem [2**ADDR_W];

	// response delay line, one slot per cycle of latency
	logic       ack_pipe  [LAT];
	logic [7:0] data_pipe [LAT];

	logic [SCNT_W-1:0] stb_seen;
	logic              accept;

	assign accept   = wb.cyc && wb.stb && !wb.stall;
	assign wb.ack   = ack_pipe[LAT-1];
	assign wb.dat_r = data_pipe[LAT-1];

	always_ff @(posedge CLK_I) begin
		if (accept && wb.we)
			mem[wb.adr[ADDR_W-1:0]] <= wb.dat_w;
	end

	always_ff @(posedge CLK_I) begin
		data_pipe[0] <= mem[wb.adr[ADDR_W-1:0]];
		for (int i = 1; i < LAT; i++)
			data_pipe[i] <= data_pipe[i-1];
	end

	always_ff @(posedge CLK_I) begin
		if (RST_I) begin
			for (int i = 0; i < LAT; i++)
				ack_pipe[i] <= 1'b0;
			wb.stall <= 1'b0;
			stb_seen <= '0;
		end else begin
			ack_pipe[0] <= accept;
			for (int i = 1; i < LAT; i++)
				ack_pipe[i] <= ack_pipe[i-1];

			// single stall cycle after every EVERY accepted strobes
			wb.stall <= 1'b0;
			if (accept) begin
				if (stb_seen == SCNT_W'(EVERY - 1)) begin
					stb_seen <= '0;
					wb.stall <= 1'b1;
				end else begin
					stb_seen <= stb_seen + 1'b1;
				end
			end
		end
	end

endmodule

// ==== src/bus_subsys.sv ====
`timescale 1ns/1ps

module bus_subsys (
	input  logic              CLK_I,
	input  logic              RST_I,
	input  logic              req,
	input  bus_pkg::bus_op_e  op,
	input  logic [31:0]       addr,
	input  logic [31:0]       wdata,
	output logic              ack,
	output logic [31:0]       rdata
);

	// read completion from master back to the host port
	logic        rsp_valid;
	logic [31:0] rsp_data;

	bus_cmd_if host_cmd ();
	bus_cmd_if queue_cmd ();
	wb8_if     wb ();

	host_port host_port_i (
		.CLK_I     (CLK_I),
		.RST_I     (RST_I),
		.req       (req),
		.op        (op),
		.addr      (addr),
		.wdata     (wdata),
		.ack       (ack),
		.rdata     (rdata),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data),
		.cmd       (host_cmd.source)
	);

	cmd_queue cmd_queue_i (
		.CLK_I (CLK_I),
		.RST_I (RST_I),
		.in    (host_cmd.sink),
		.out   (queue_cmd.source)
	);

	wb8_master wb8_master_i (
		.CLK_I     (CLK_I),
		.RST_I     (RST_I),
		.cmd       (queue_cmd.sink),
		.wb        (wb.master),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data)
	);

	wb_ram8 wb_ram8_i (
		.CLK_I (CLK_I),
		.RST_I (RST_I),
		.wb    (wb.slave)
	);

endmodule

// ==== dv/bus_subsys_asserts.sv ====
`timescale 1ns/1ps

module bus_subsys_asserts (
	input logic CLK_I,
	input logic RST_I,
	input logic cyc,
	input logic stb,
	input logic stall,
	input logic ack,
	input logic rsp_valid
);

	// strobes accepted since the current bus cycle opened
	logic [3:0] taken;
	// number of assertion failures so far
	int         fail_count = 0;

	always_ff @(posedge CLK_I) begin
		if (RST_I || !cyc)
			taken <= '0;
		else
			taken <= taken + {3'd0, stb && !stall};
	end

	stb_needs_cyc: assert property (@(posedge CLK_I) disable iff (RST_I) stb |-> cyc)
		else begin
			fail_count++;
			$error("strobe raised outside a bus cycle");
		end

	ack_in_cycle: assert property (@(posedge CLK_I) disable iff (RST_I) ack |-> cyc)
		else begin
			fail_count++;
			$error("ack seen while no bus cycle is open");
		end

	in_flight_limit: assert property (@(posedge CLK_I) disable iff (RST_I) taken <= 4'd4)
		else begin
			fail_count++;
			$error("more than four transfers in one bus cycle");
		end

	// read completion is a single cycle pulse
	rsp_one_cycle: assert property (@(posedge CLK_I) disable iff (RST_I)
		rsp_valid |=> !rsp_valid)
		else begin
			fail_count++;
			$error("read response held for more than one cycle");
		end

endmodule

bind wb8_master bus_subsys_asserts asserts_i (
	.CLK_I     (CLK_I),
	.RST_I     (RST_I),
	.cyc       (wb.cyc),
	.stb       (wb.stb),
	.stall     (wb.stall),
	.ack       (wb.ack),
	.rsp_valid (rsp_valid)
);

// ==== dv/bus_subsys_tb.sv ====
`timescale 1ns/1ps

module bus_subsys_tb;
	import bus_pkg::*;

	typedef struct {
		bus_op_e     op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] exp;
		bit          burst;
	} entry_t;

	logic        CLK_I;
	logic        RST_I;
	logic        req;
	bus_op_e     op;
	logic [31:0] addr;
	logic [31:0] wdata;
	logic        ack;
	logic [31:0] rdata;

	entry_t      tests[$];
	logic [15:0] lfsr;
	int          cycles;
	int          limit;
	bit          saw_full;

	bus_subsys dut_i (
		.CLK_I (CLK_I),
		.RST_I (RST_I),
		.req   (req),
		.op    (op),
		.addr  (addr),
		.wdata (wdata),
		.ack   (ack),
		.rdata (rdata)
	);

	initial begin
		CLK_I = 1'b0;
		forever #20 CLK_I = ~CLK_I;
	end

	always @(posedge CLK_I) begin
		cycles++;
		if (cycles >= limit) begin
			$display("timeout: requests did not complete within %0d cycles", limit);
			$display(">>> FAIL");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// host to queue ready low means the queue is full
	always @(posedge CLK_I) begin
		if (!RST_I && dut_i.host_cmd.ready === 1'b0)
			saw_full = 1'b1;
	end

	// 16 bit fibonacci lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic next_gap(output int gap);
		gap = 0;
		for (int i = 0; i < 2; i++) begin
			lfsr = lfsr_next(lfsr);
			gap  = (gap << 1) | lfsr[0];
		end
	endtask

	task automatic compare_values(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
			$display(">>> FAIL");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge CLK_I);
			#2;
		end
	endtask

	task automatic add_entry(input bus_op_e o, input logic [31:0] a, input logic [31:0] d,
		input logic [31:0] e, input bit b);
		entry_t t;
		t.op    = o;
		t.addr  = a;
		t.wdata = d;
		t.exp   = e;
		t.burst = b;
		tests.push_back(t);
	endtask

	task automatic load_tests();
		// word write then reads of every width, little endian
		add_entry(OP_WRITEW, 32'h10, 32'h8765_43A1, 32'h0, 1'b0);
		add_entry(OP_READW, 32'h10, 32'h0, 32'h8765_43A1, 1'b0);
		add_entry(OP_READB, 32'h10, 32'h0, 32'hFFFF_FFA1, 1'b0);
		add_entry(OP_READBU, 32'h10, 32'h0, 32'h0000_00A1, 1'b0);
		add_entry(OP_READH, 32'h12, 32'h0, 32'hFFFF_8765, 1'b0);
		add_entry(OP_READHU, 32'h12, 32'h0, 32'h0000_8765, 1'b0);
		add_entry(OP_READB, 32'h11, 32'h0, 32'h0000_0043, 1'b0);
		add_entry(OP_READH, 32'h10, 32'h0, 32'h0000_43A1, 1'b0);
		// partial writes merge into the word
		add_entry(OP_WRITEW, 32'h20, 32'h1122_3344, 32'h0, 1'b0);
		add_entry(OP_WRITEB, 32'h21, 32'hDEAD_BEC7, 32'h0, 1'b0);
		add_entry(OP_WRITEH, 32'h22, 32'h0000_F00D, 32'h0, 1'b0);
		add_entry(OP_READW, 32'h20, 32'h0, 32'hF00D_C744, 1'b0);
		add_entry(OP_READH, 32'h22, 32'h0, 32'hFFFF_F00D, 1'b0);
		add_entry(OP_READB, 32'h21, 32'h0, 32'hFFFF_FFC7, 1'b0);
		// posted writes with no gaps, enough to fill the queue
		add_entry(OP_WRITEW, 32'h40, 32'h0000_0001, 32'h0, 1'b1);
		add_entry(OP_WRITEW, 32'h44, 32'h0000_0002, 32'h0, 1'b1);
		add_entry(OP_WRITEW, 32'h40, 32'h0000_0003, 32'h0, 1'b1);
		add_entry(OP_WRITEW, 32'h48, 32'h0000_0004, 32'h0, 1'b1);
		add_entry(OP_WRITEW, 32'h40, 32'h0000_0005, 32'h0, 1'b1);
		add_entry(OP_WRITEW, 32'h4C, 32'h0000_0006, 32'h0, 1'b1);
		add_entry(OP_WRITEW, 32'h40, 32'hCAFE_F00D, 32'h0, 1'b1);
		add_entry(OP_WRITEW, 32'h44, 32'h1357_9BDF, 32'h0, 1'b1);
		add_entry(OP_READW, 32'h40, 32'h0, 32'hCAFE_F00D, 1'b0);
		add_entry(OP_READW, 32'h44, 32'h0, 32'h1357_9BDF, 1'b0);
		add_entry(OP_READW, 32'h48, 32'h0, 32'h0000_0004, 1'b0);
		add_entry(OP_READW, 32'h4C, 32'h0, 32'h0000_0006, 1'b0);
		add_entry(OP_WRITEB, 32'h4D, 32'h0000_0080, 32'h0, 1'b0);
		add_entry(OP_READHU, 32'h4C, 32'h0, 32'h0000_8006, 1'b0);
		add_entry(OP_READH, 32'h4C, 32'h0, 32'hFFFF_8006, 1'b0);
		add_entry(OP_READW, 32'h4C, 32'h0, 32'h0000_8006, 1'b0);
	endtask

	// one full four-phase handshake, called just after a rising edge
	task automatic run_request(input entry_t t);
		bit is_write;
		is_write = t.op inside {OP_WRITEB, OP_WRITEH, OP_WRITEW};
		req   = 1'b1;
		op    = t.op;
		addr  = t.addr;
		wdata = t.wdata;
		// a full queue or a pending read delays ack
		do begin
			@(posedge CLK_I);
			#2;
		end while (ack !== 1'b1);
		if (!is_write)
			compare_values("rdata", rdata, t.exp);
		req = 1'b0;
		idle_cycles(1);
		compare_values("ack", {31'd0, ack}, 32'd0);
	endtask

	initial begin
		int gap;
		req      = 1'b0;
		op       = OP_READW;
		addr     = '0;
		wdata    = '0;
		RST_I    = 1'b1;
		lfsr     = 16'd60810;
		saw_full = 1'b0;
		cycles   = 0;
		load_tests();
		limit = tests.size() * 80 + 50;

		idle_cycles(8);
		RST_I = 1'b0;
		compare_values("ack", {31'd0, ack}, 32'd0);

		foreach (tests[i]) begin
			run_request(tests[i]);
			if (!tests[i].burst) begin
				next_gap(gap);
				idle_cycles(gap);
			end
		end

		compare_values("queue_full_seen", {31'd0, saw_full}, 32'd1);
		if (dut_i.wb8_master_i.asserts_i.fail_count != 0) begin
			$display("bus protocol assertions failed %0d times",
				dut_i.wb8_master_i.asserts_i.fail_count);
			$display(">>> FAIL");
			$fatal(1, "assertion failures during the run");
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

// ==== compile.f ====
+incdir+include
src/bus_pkg.sv
src/bus_cmd_if.sv
src/wb8_if.sv
src/host_port.sv
src/cmd_queue.sv
src/wb8_master.sv
src/wb_ram8.sv
src/bus_subsys.sv
dv/bus_subsys_asserts.sv
dv/bus_subsys_tb.sv
